/* verilog/tart_consts.svh */
`ifndef TART_CONSTS_SVH
`define TART_CONSTS_SVH

// ----------------------------------------------------------------------
// Antenna capture
// ----------------------------------------------------------------------
`define AX_NUM        4     // Single-bit antenna inputs
`define AX_TAPS       8     // Delay-line length, 3-bit select

// Sample buffer
`define BUF_DEPTH     16    // Bytes
`define BUF_LVL_BITS  5     // Holds 0..BUF_DEPTH

// Register map, adr[3] picks the buffer
`define REG_CTRL      4'h0
`define REG_DELAY     4'h1
`define REG_STATUS    4'h2
`define REG_LEVEL     4'h3
`define REG_DATA      4'h8

`endif

/* verilog/tart_pkg.sv */
`default_nettype none

`include "tart_consts.svh"

package tart_pkg;

   // Acquisition FSM, also shown on the status output
   typedef enum logic [1:0] {
      AQ_IDLE = 2'd0,               // Disabled
      AQ_RUN  = 2'd1,               // Enabled, buffer has room
      AQ_FULL = 2'd2                // Enabled, buffer full
   } aq_state_e;

   // Decoded bus cycle as seen by a slave
   typedef enum logic [1:0] {
      BUS_IDLE  = 2'd0,
      BUS_READ  = 2'd1,
      BUS_WRITE = 2'd2
   } bus_op_e;

   // ----------------------------------------------------------------------
   // Bus, master to slave and back
   // ----------------------------------------------------------------------
   typedef struct packed {
      logic       cyc;
      logic       stb;
      logic       we;
      logic [3:0] adr;
      logic [7:0] dat;
   } bus_req_t;

   typedef struct packed {
      logic       ack;
      logic [7:0] dat;              // Valid in the ack cycle only
   } bus_rsp_t;

   // ----------------------------------------------------------------------
   // Stage pipeline, valid-only
   // ----------------------------------------------------------------------
   typedef struct packed {
      logic                valid;
      logic [`AX_NUM-1:0]  sample;   // One bit per antenna
   } sample_t;

   typedef struct packed {
      logic                  valid;
      logic [2*`AX_NUM-1:0]  data;   // Second sample in the high nibble
   } byte_t;

   typedef struct packed {
      logic                        enable;
      logic                        debug;   // Counter replaces antennas
      logic [$clog2(`AX_TAPS)-1:0] delay;
   } aq_cfg_t;

endpackage

`default_nettype wire

/* verilog/ax_capture.sv */
`timescale 1ns/100ps
`default_nettype none

`include "tart_consts.svh"

module ax_capture (
   input  wire logic                 b_clk,
   input  wire logic                 rst_n_i,
   input  wire tart_pkg::aq_cfg_t    cfg_i,
   input  wire logic [`AX_NUM-1:0]   antenna_i,
   output tart_pkg::sample_t         smp_o
);

   logic [`AX_NUM-1:0] taps_q [`AX_TAPS];   // taps_q[0] is the newest word
   logic [`AX_NUM-1:0] cnt_q;               // Debug ramp
   logic [`AX_NUM-1:0] smp_q;
   logic               vld_q;

   // ----------------------------------------------------------------------
   // Delay line and tap select
   // ----------------------------------------------------------------------
   always_ff @(posedge b_clk) begin
      taps_q[0] <= antenna_i;
      for (int i = 1; i < `AX_TAPS; i++) begin
         taps_q[i] <= taps_q[i-1];
      end
      // Tap d holds the word registered d+1 edges back
      smp_q <= cfg_i.debug ? cnt_q : taps_q[cfg_i.delay];
   end

   // Valid and debug counter both track enable
   always_ff @(posedge b_clk) begin
      if (!rst_n_i) begin
         vld_q <= 1'b0;
         cnt_q <= '0;
      end else begin
         vld_q <= cfg_i.enable;           // One sample per cycle while on
         if (!cfg_i.enable)
            cnt_q <= '0;                  // Restart ramp at 0
         else
            cnt_q <= cnt_q + 1'b1;        // Wraps modulo 16
      end
   end

   assign smp_o.valid  = vld_q;
   assign smp_o.sample = smp_q;

endmodule

`default_nettype wire

/* verilog/ax_packer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "tart_consts.svh"

module ax_packer (
   input  wire logic                b_clk,
   input  wire logic                rst_n_i,
   input  wire logic                en_i,     // Enable bit only
   input  wire tart_pkg::sample_t   smp_i,
   output tart_pkg::byte_t          byte_o
);

   logic                   phase_q;  // Set when a low nibble is held
   logic [`AX_NUM-1:0]     lo_q;
   logic [2*`AX_NUM-1:0]   dat_q;
   logic                   vld_q;

   // ----------------------------------------------------------------------
   // Pairing phase
   // ----------------------------------------------------------------------
   always_ff @(posedge b_clk) begin
      if (!rst_n_i) begin
         phase_q <= 1'b0;
         vld_q   <= 1'b0;
      end else begin
         vld_q <= smp_i.valid && phase_q;   // Pair completes this cycle
         if (!en_i)
            phase_q <= 1'b0;                // Next sample is a low nibble
         else if (smp_i.valid)
            phase_q <= !phase_q;
      end
   end

   // Nibble hold and byte assembly
   always_ff @(posedge b_clk) begin
      if (smp_i.valid && !phase_q)
         lo_q <= smp_i.sample;              // First of the pair
      if (smp_i.valid && phase_q)
         dat_q <= {smp_i.sample, lo_q};     // Second goes high
   end

   assign byte_o.valid = vld_q;
   assign byte_o.data  = dat_q;

endmodule

`default_nettype wire

/* verilog/aq_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "tart_consts.svh"

module aq_buffer (
   input  wire logic                      b_clk,
   input  wire logic                      rst_n_i,
   input  wire tart_pkg::byte_t           byte_i,
   input  wire tart_pkg::bus_req_t        bus_i,
   output tart_pkg::bus_rsp_t             bus_o,
   output logic [`BUF_LVL_BITS-1:0]       level_o,
   output logic                           full_o,
   output logic                           ovf_o
);
   import tart_pkg::*;

   localparam int PTR_BITS = $clog2(`BUF_DEPTH);
   localparam logic [`BUF_LVL_BITS-1:0] LVL_FULL = `BUF_LVL_BITS'(`BUF_DEPTH);

   logic [7:0]               mem [`BUF_DEPTH];
   logic [PTR_BITS-1:0]      wptr_q, rptr_q;
   logic [`BUF_LVL_BITS-1:0] level_q;
   logic                     ovf_q, ack_q;
   logic [7:0]               dat_q;
   bus_op_e                  op;
   logic                     push, pop, flush;

   // New cycle only, the ack cycle itself is ignored
   always_comb begin
      if (!bus_i.cyc || !bus_i.stb || ack_q) op = BUS_IDLE;
      else if (bus_i.we)                    op = BUS_WRITE;
      else                                  op = BUS_READ;
   end

   assign full_o = level_q == LVL_FULL;
   assign flush  = op == BUS_WRITE;                 // Any write empties the FIFO
   assign pop    = op == BUS_READ && bus_i.adr == `REG_DATA && level_q != '0;
   assign push   = byte_i.valid && !full_o && !flush;

   // ----------------------------------------------------------------------
   // Storage and read data
   // ----------------------------------------------------------------------
   always_ff @(posedge b_clk) begin
      if (push)
         mem[wptr_q] <= byte_i.data;
      if (op == BUS_READ)
         dat_q <= pop ? mem[rptr_q] : 8'h00;        // Empty reads give 0
   end

   // Pointers, level and overflow
   always_ff @(posedge b_clk) begin
      if (!rst_n_i) begin
         ack_q   <= 1'b0;
         wptr_q  <= '0;
         rptr_q  <= '0;
         level_q <= '0;
         ovf_q   <= 1'b0;
      end else begin
         ack_q <= op != BUS_IDLE;
         if (flush) begin
            wptr_q  <= '0;
            rptr_q  <= '0;
            level_q <= '0;
            ovf_q   <= 1'b0;
         end else begin
            if (push) wptr_q <= wptr_q + 1'b1;     // Wraps at depth
            if (pop)  rptr_q <= rptr_q + 1'b1;
            case ({push, pop})
               2'b10:   level_q <= level_q + 1'b1;
               2'b01:   level_q <= level_q - 1'b1;
               default: level_q <= level_q;
            endcase
            if (byte_i.valid && full_o)
               ovf_q <= 1'b1;                       // Sticky until flush
         end
      end
   end

   assign level_o   = level_q;
   assign ovf_o     = ovf_q;
   assign bus_o.ack = ack_q;
   assign bus_o.dat = dat_q;

endmodule

`default_nettype wire

/* verilog/aq_control.sv */
`timescale 1ns/100ps
`default_nettype none

`include "tart_consts.svh"

module aq_control (
   input  wire logic                      b_clk,
   input  wire logic                      rst_n_i,
   input  wire tart_pkg::bus_req_t        bus_i,
   output tart_pkg::bus_rsp_t             bus_o,
   input  wire logic [`BUF_LVL_BITS-1:0]  level_i,
   input  wire logic                      full_i,
   input  wire logic                      ovf_i,
   output tart_pkg::aq_cfg_t              cfg_o,
   output tart_pkg::aq_state_e            state_o
);
   import tart_pkg::*;

   aq_cfg_t   cfg_q;
   aq_state_e state_q, state_nx;
   bus_op_e   op;
   logic      ack_q;
   logic [7:0] dat_q, rd_val;

   always_comb begin
      if (!bus_i.cyc || !bus_i.stb || ack_q) op = BUS_IDLE;
      else if (bus_i.we)                    op = BUS_WRITE;
      else                                  op = BUS_READ;
   end

   // ----------------------------------------------------------------------
   // Register read mux
   // ----------------------------------------------------------------------
   always_comb begin
      rd_val = 8'h00;
      case (bus_i.adr)
         `REG_CTRL:   rd_val = {6'b0, cfg_q.debug, cfg_q.enable};
         `REG_DELAY:  rd_val = 8'(cfg_q.delay);
         `REG_STATUS: rd_val = {5'b0, ovf_i, state_q};
         `REG_LEVEL:  rd_val = 8'(level_i);
         default:     rd_val = 8'h00;     // Unmapped
      endcase
   end

   // Acquisition FSM, one cycle behind enable and full
   always_comb begin
      state_nx = state_q;
      case (state_q)
         AQ_IDLE: if (cfg_q.enable) state_nx = full_i ? AQ_FULL : AQ_RUN;
         AQ_RUN:  if (!cfg_q.enable) state_nx = AQ_IDLE;
                  else if (full_i)  state_nx = AQ_FULL;
         AQ_FULL: if (!cfg_q.enable) state_nx = AQ_IDLE;
                  else if (!full_i) state_nx = AQ_RUN;
         default: state_nx = AQ_IDLE;
      endcase
   end

   always_ff @(posedge b_clk) begin
      if (!rst_n_i) begin
         ack_q   <= 1'b0;
         cfg_q   <= '0;
         state_q <= AQ_IDLE;
      end else begin
         ack_q   <= op != BUS_IDLE;        // One cycle after stb
         state_q <= state_nx;
         if (op == BUS_WRITE) begin
            case (bus_i.adr)
               `REG_CTRL: begin
                  cfg_q.enable <= bus_i.dat[0];
                  cfg_q.debug  <= bus_i.dat[1];
               end
               `REG_DELAY: cfg_q.delay <= bus_i.dat[2:0];
               default: ;                  // Status and level are read-only
            endcase
         end
      end
   end

   always_ff @(posedge b_clk) begin
      if (op == BUS_READ)
         dat_q <= rd_val;
   end

   assign bus_o.ack = ack_q;
   assign bus_o.dat = dat_q;
   assign cfg_o     = cfg_q;
   assign state_o   = state_q;

endmodule

`default_nettype wire

/* verilog/bus_select.sv */
`timescale 1ns/100ps
`default_nettype none

module bus_select (
   input  wire logic                b_clk,
   input  wire logic                rst_n_i,
   input  wire tart_pkg::bus_req_t  bus_i,
   output tart_pkg::bus_req_t       ctl_o,
   output tart_pkg::bus_req_t       buf_o,
   input  wire tart_pkg::bus_rsp_t  ctl_i,
   input  wire tart_pkg::bus_rsp_t  buf_i,
   output tart_pkg::bus_rsp_t       bus_o
);

   logic ctl_hit, buf_hit;       // Address decode on adr[3]
   logic ctl_sel_q, buf_sel_q;   // Held until the slave acks

   assign ctl_hit = bus_i.cyc && bus_i.stb && !bus_i.adr[3];
   assign buf_hit = bus_i.cyc && bus_i.stb &&  bus_i.adr[3];

   // ----------------------------------------------------------------------
   // Held selection, costs one cycle before the slave sees stb
   // ----------------------------------------------------------------------
   always_ff @(posedge b_clk) begin
      if (!rst_n_i || !bus_i.cyc) begin
         ctl_sel_q <= 1'b0;
         buf_sel_q <= 1'b0;
      end else begin
         ctl_sel_q <= ctl_sel_q ? !ctl_i.ack : ctl_hit && !buf_sel_q;
         buf_sel_q <= buf_sel_q ? !buf_i.ack : buf_hit && !ctl_sel_q;
      end
   end

   // Request fan-out with gated strobes
   always_comb begin
      ctl_o     = bus_i;
      ctl_o.stb = bus_i.stb && ctl_sel_q;
      buf_o     = bus_i;
      buf_o.stb = bus_i.stb && buf_sel_q;
   end

   // Response merge
   assign bus_o.ack = ctl_i.ack || buf_i.ack;
   assign bus_o.dat = ctl_sel_q ? ctl_i.dat : buf_i.dat;

endmodule

`default_nettype wire

/* verilog/tart_aq_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "tart_consts.svh"

module tart_aq_top (
   input  wire logic                b_clk,
   input  wire logic                rst_n_i,
   input  wire tart_pkg::bus_req_t  bus_i,
   output tart_pkg::bus_rsp_t       bus_o,
   input  wire logic [`AX_NUM-1:0]  antenna_i,
   output tart_pkg::aq_state_e      state_o    // LED-style status
);
   import tart_pkg::*;

   bus_req_t                 ctl_req, buf_req;
   bus_rsp_t                 ctl_rsp, buf_rsp;
   aq_cfg_t                  cfg;
   sample_t                  smp;
   byte_t                    byt;
   logic [`BUF_LVL_BITS-1:0] level;
   logic                     full, ovf;

   // ----------------------------------------------------------------------
   // Host side
   // ----------------------------------------------------------------------
   bus_select SEL0 (
      .b_clk(b_clk), .rst_n_i(rst_n_i),
      .bus_i(bus_i), .bus_o(bus_o),
      .ctl_o(ctl_req), .ctl_i(ctl_rsp),
      .buf_o(buf_req), .buf_i(buf_rsp)
   );

   aq_control CTL0 (
      .b_clk(b_clk), .rst_n_i(rst_n_i),
      .bus_i(ctl_req), .bus_o(ctl_rsp),
      .level_i(level), .full_i(full), .ovf_i(ovf),
      .cfg_o(cfg), .state_o(state_o)
   );

   // ----------------------------------------------------------------------
   // Capture, pack, buffer
   // ----------------------------------------------------------------------
   ax_capture CAP0 (
      .b_clk(b_clk), .rst_n_i(rst_n_i),
      .cfg_i(cfg), .antenna_i(antenna_i), .smp_o(smp)
   );

   ax_packer PCK0 (
      .b_clk(b_clk), .rst_n_i(rst_n_i),
      .en_i(cfg.enable), .smp_i(smp), .byte_o(byt)
   );

   aq_buffer BUF0 (
      .b_clk(b_clk), .rst_n_i(rst_n_i),
      .byte_i(byt), .bus_i(buf_req), .bus_o(buf_rsp),
      .level_o(level), .full_o(full), .ovf_o(ovf)
   );

endmodule

`default_nettype wire

/* tb/tart_aq_sva.sv */
`timescale 1ns/100ps
`default_nettype none

`include "tart_consts.svh"

module tart_aq_sva #(
   parameter bit HAS_FIFO = 1'b1                     // Level and full checks on the buffer only
) (
   input  wire logic                      b_clk,
   input  wire logic                      rst_n_i,
   input  wire logic                      stb_i,
   input  wire logic                      ack_i,
   input  wire logic [`BUF_LVL_BITS-1:0]  level_i,   // Tied low where there is no FIFO
   input  wire logic                      full_i
);

   // ----------------------------------------------------------------------
   // Bus handshake
   // ----------------------------------------------------------------------
   ack_needs_stb: assert property (@(posedge b_clk) disable iff (!rst_n_i)
      ack_i |-> stb_i) else $error("ack seen without stb");

   // Single-cycle ack
   ack_one_cycle: assert property (@(posedge b_clk) disable iff (!rst_n_i)
      ack_i |=> !ack_i) else $error("ack held for more than one cycle");

   // FIFO level bounds
   if (HAS_FIFO) begin : fifo_chk
      level_in_range: assert property (@(posedge b_clk) disable iff (!rst_n_i)
         level_i <= `BUF_DEPTH) else $error("level above buffer depth");

      full_at_depth: assert property (@(posedge b_clk) disable iff (!rst_n_i)
         full_i |-> level_i == `BUF_DEPTH) else $error("full flag with level below depth");
   end

endmodule

bind aq_buffer tart_aq_sva BUF_SVA (
   .b_clk(b_clk), .rst_n_i(rst_n_i),
   .stb_i(bus_i.stb), .ack_i(bus_o.ack),
   .level_i(level_o), .full_i(full_o)
);

bind bus_select tart_aq_sva #(.HAS_FIFO(1'b0)) SEL_SVA (
   .b_clk(b_clk), .rst_n_i(rst_n_i),
   .stb_i(bus_i.stb), .ack_i(bus_o.ack),      // Host side of the decoder
   .level_i('0), .full_i(1'b0)
);

`default_nettype wire

/* tb/tb_tart_aq.sv */
`timescale 1ns/100ps
`default_nettype none

`include "tart_consts.svh"

module tb_tart_aq;
   import tart_pkg::*;

   localparam int ACK_TMO  = 20;      // Cycles per bus access
   localparam int LVL_TMO  = 60;      // Level polls before giving up
   localparam int HIST_LEN = 16384;

   logic                b_clk = 1'b0;
   logic                rst_n_i;
   bus_req_t            bus_i;
   bus_rsp_t            bus_o;
   logic [`AX_NUM-1:0]  antenna_i = '0;
   aq_state_e           state_o;

   logic [31:0]         lfsr_q = 32'h1081_77d8;
   logic [`AX_NUM-1:0]  ant_hist [HIST_LEN];   // Indexed by the edge that samples it
   int                  cyc_cnt = 0;            // Rising edges so far
   int                  n_checks = 0;
   int                  n_errors = 0;
   bit                  aborted = 1'b0;
   int                  en_ack_cyc = 0;         // Ack edge of the last enabling write
   int                  delay_set = 0;

   tart_aq_top UUT (
      .b_clk(b_clk), .rst_n_i(rst_n_i),
      .bus_i(bus_i), .bus_o(bus_o),
      .antenna_i(antenna_i), .state_o(state_o)
   );

   always #2 b_clk = ~b_clk;            // 4 ns period

   always @(posedge b_clk) cyc_cnt <= cyc_cnt + 1;

   // ----------------------------------------------------------------------
   // Antenna stimulus from a Galois LFSR
   // ----------------------------------------------------------------------
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      lfsr_next = s[0] ? (s >> 1) ^ 32'h8020_0003 : s >> 1;   // x^32+x^22+x^2+x+1
   endfunction

   always @(negedge b_clk) begin : drive_antenna
      logic [`AX_NUM-1:0] nib;
      logic [31:0]        s;
      s = lfsr_q;
      for (int b = 0; b < `AX_NUM; b++) begin
         nib[b] = s[0];                 // One step per bit
         s = lfsr_next(s);
      end
      lfsr_q    <= s;
      antenna_i <= nib;
      if (cyc_cnt + 1 < HIST_LEN)
         ant_hist[cyc_cnt + 1] <= nib;  // Sampled at the next rising edge
   end

   // Counter ramp, first sample 0, pairs packed low nibble first
   function automatic logic [7:0] debug_byte(input int j);
      logic [3:0] lo, hi;
      lo = 4'(2 * j);
      hi = 4'(2 * j + 1);
      debug_byte = {hi, lo};
   endfunction

   // First sample lands one edge after the ack and picks the word d+1 edges back
   function automatic logic [7:0] antenna_byte(input int j);
      int base;
      base = en_ack_cyc - delay_set + 2 * j;
      antenna_byte = {ant_hist[base + 1], ant_hist[base]};
   endfunction

   // ----------------------------------------------------------------------
   // Bus access and checks
   // ----------------------------------------------------------------------
   task automatic bus_xfer(input logic we, input logic [3:0] adr, input logic [7:0] dat,
                           output logic [7:0] rd, output int ack_cyc);
      int waited;
      waited = 0;
      @(negedge b_clk);
      bus_i.cyc = 1'b1;
      bus_i.stb = 1'b1;
      bus_i.we  = we;
      bus_i.adr = adr;
      bus_i.dat = dat;
      do begin
         @(negedge b_clk);
         waited++;
      end while (!bus_o.ack && waited < ACK_TMO);
      if (!bus_o.ack) begin
         $display("Timeout: no ack from address %h within %0d cycles", adr, ACK_TMO);
         n_errors++;
         aborted = 1'b1;
      end
      rd      = bus_o.dat;              // Valid in the ack cycle
      ack_cyc = cyc_cnt;
      @(negedge b_clk);                 // Strobe held over the edge that sees ack
      bus_i.cyc = 1'b0;
      bus_i.stb = 1'b0;
   endtask

   task automatic check_val(input logic [8*24-1:0] name, input logic [7:0] exp,
                            input logic [7:0] act);
      n_checks++;
      if (act !== exp) begin
         n_errors++;
         $display("FAILED %0s expected %02h actual %02h", name, exp, act);
      end
   endtask

   task automatic wait_level(input logic [7:0] target, input logic [8*24-1:0] name);
      logic [7:0] lvl;
      int         ac;
      int         polls;
      lvl   = 8'h00;
      polls = 0;
      while (lvl < target && polls < LVL_TMO && !aborted) begin
         bus_xfer(1'b0, `REG_LEVEL, 8'h00, lvl, ac);
         polls++;
      end
      if (lvl < target && !aborted) begin
         $display("Timeout in %0s: buffer level stuck at %0d, wanted %0d", name, lvl, target);
         n_errors++;
         aborted = 1'b1;
      end
   endtask

   // ----------------------------------------------------------------------
   // Main sequence, one file line per operation
   // ----------------------------------------------------------------------
   initial begin : run_tests
      int               fd;
      int               nf;
      int               ac;
      logic [8*128-1:0] line;
      logic [8*24-1:0]  name;
      logic [7:0]       op;
      logic [3:0]       adr;
      logic [7:0]       dat, exp, rd;
      rst_n_i = 1'b0;
      bus_i   = '0;
      repeat (4) @(negedge b_clk);      // 4 cycles in reset
      rst_n_i = 1'b1;

      fd = $fopen("tb/tart_aq_input.txt", "r");
      if (fd == 0) begin
         $display("Could not open the stimulus file tb/tart_aq_input.txt");
         n_errors++;
         aborted = 1'b1;
      end
      while (fd != 0 && !$feof(fd) && !aborted) begin
         line = '0;
         nf = $fgets(line, fd);
         nf = $sscanf(line, "%s %s %h %h %h", name, op, adr, dat, exp);
         if (nf == 5) begin             // Comments and blank lines fall out here
            case (op)
               "W": begin
                  bus_xfer(1'b1, adr, dat, rd, ac);
                  if (adr == `REG_CTRL && dat[0])
                     en_ack_cyc = ac;
                  if (adr == `REG_DELAY)
                     delay_set = int'(dat[2:0]);
               end
               "R": begin
                  bus_xfer(1'b0, adr, 8'h00, rd, ac);
                  check_val(name, exp, rd);
               end
               "S": check_val(name, exp, 8'(state_o));
               "L": wait_level(dat, name);
               "I": repeat (dat) @(negedge b_clk);
               "D", "A": begin
                  for (int j = 0; j < dat && !aborted; j++) begin
                     bus_xfer(1'b0, adr, 8'h00, rd, ac);
                     check_val(name, (op == "D") ? debug_byte(j) : antenna_byte(j), rd);
                  end
               end
               default: begin
                  $display("Unknown operation %0s on stimulus line %0s", op, name);
                  n_errors++;
               end
            endcase
         end
      end
      if (fd != 0)
         $fclose(fd);
      if (n_checks == 0) begin
         $display("No checks were run");
         n_errors++;
      end

      $display("Checks run: %0d  errors: %0d", n_checks, n_errors);
      if (n_errors == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

   // Hard stop in case a loop escapes its own limit
   initial begin : watchdog
      #40000;
      $display("Simulation stopped by the watchdog after %0d cycles", cyc_cnt);
      $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* tb/tart_aq_input.txt */
# Columns: name op adr dat exp, with adr, dat and exp in hex
# Ops: W write, R read and compare, S state, L level poll, I idle, D debug bytes, A antenna bytes
rst_ctrl       R 0 00 00
rst_status     R 2 00 00
rst_level      R 3 00 00
rst_state      S 0 00 00
delay_write    W 1 05 00
delay_read     R 1 00 05
dbg_enable     W 0 03 00
dbg_fill       L 3 06 00
dbg_disable    W 0 00 00
dbg_bytes      D 8 06 00
dbg_flush      W 8 00 00
ant_delay      W 1 03 00
ant_enable     W 0 01 00
ant_fill       L 3 06 00
ant_disable    W 0 00 00
ant_bytes      A 8 06 00
ant_flush      W 8 00 00
full_delay     W 1 06 00
full_enable    W 0 01 00
full_fill      L 3 10 00
full_settle    I 0 04 00
full_level     R 3 00 10
full_status    R 2 00 06
full_state     S 0 00 02
full_disable   W 0 00 00
full_idle_sts  R 2 00 04
full_bytes     A 8 10 00
empty_read     R 8 00 00
flush          W 8 00 00
flush_level    R 3 00 00
flush_status   R 2 00 00
flush_state    S 0 00 00

/* sim.f */
+incdir+verilog
verilog/tart_pkg.sv
verilog/ax_capture.sv
verilog/ax_packer.sv
verilog/aq_buffer.sv
verilog/aq_control.sv
verilog/bus_select.sv
verilog/tart_aq_top.sv
tb/tart_aq_sva.sv
tb/tb_tart_aq.sv

/* Makefile */
VERILATOR  = verilator
FLAGS      = --binary --timing --assert --timescale 1ns/100ps
LINT_FLAGS = --lint-only -Wall --timing --timescale 1ns/100ps
TOP        = tb_tart_aq
FILELIST   = sim.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "SOME TESTS FAILED" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
